//--- Bender.yml
package:
  name: decode_stage

sources:
  - include_dirs:
      - design
    files:
      - design/de_pkg.sv
      - design/inst_decoder.sv
      - design/imm_gen.sv
      - design/reg_file.sv
      - design/scoreboard.sv
      - design/decode_stage.sv
  - target: simulation
    files:
      - sim/decode_stage_sva.sv
      - sim/decode_stage_tb.sv

//--- design/de_macros.svh
`ifndef DE_MACROS_SVH
`define DE_MACROS_SVH

// datapath sizes
`define XLEN        32
`define REG_COUNT   32
`define REGNO_BITS  5

// major opcodes, inst[6:0]
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111
`define OPC_BRANCH  7'b1100011

// funct3, inst[14:12]
`define F3_ADD      3'b000  // also SUB, ADDI
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SR       3'b101  // SRL and SRA, split by funct7
`define F3_OR       3'b110
`define F3_AND      3'b111
`define F3_MUL      3'b000
`define F3_WORD     3'b010  // LW / SW
`define F3_JALR     3'b000
`define F3_BEQ      3'b000
`define F3_BNE      3'b001
`define F3_BLT      3'b100
`define F3_BGE      3'b101
`define F3_BLTU     3'b110
`define F3_BGEU     3'b111

// funct7, inst[31:25]
`define F7_BASE     7'b0000000
`define F7_ALT      7'b0100000  // SUB, SRA, SRAI
`define F7_MULDIV   7'b0000001

`endif

//--- design/de_pkg.sv
`default_nettype none

`include "de_macros.svh"

package de_pkg;

  typedef logic [`XLEN-1:0]       word_t;
  typedef logic [`REGNO_BITS-1:0] regno_t;
  typedef logic [31:0]            inst_t;

  // internal operation code, a bubble (all zero) reads as OP_INVALID
  typedef enum logic [5:0] {
    OP_INVALID = 6'd0,
    // register-register
    OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
    OP_SLT, OP_SLTU, OP_SRA, OP_SRL, OP_SLL,
    OP_MUL,
    // register-immediate
    OP_ADDI, OP_ANDI, OP_ORI, OP_XORI, OP_SLTI,
    OP_SLTIU, OP_SRAI, OP_SRLI, OP_SLLI,
    // upper immediates, memory, jumps
    OP_LUI, OP_AUIPC,
    OP_LW, OP_SW,
    OP_JAL, OP_JALR,
    // conditional branches
    OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU
  } op_t;

  // which immediate format the instruction carries
  typedef enum logic [2:0] {
    IMM_NONE = 3'd0,
    IMM_I,
    IMM_S,
    IMM_B,
    IMM_U,
    IMM_J
  } imm_kind_t;

endpackage

`default_nettype wire

//--- design/decode_stage.sv
`timescale 1ns/100ps
`default_nettype none

module decode_stage (
  input  logic             clk,
  input  logic             reset,
  // from fetch
  input  logic             fe_valid,
  input  de_pkg::inst_t    fe_inst,
  input  de_pkg::word_t    fe_pc,
  // from execute
  input  logic             flush,
  // from write-back
  input  logic             wb_wr_reg,
  input  de_pkg::regno_t   wb_regno,
  input  de_pkg::word_t    wb_regval,
  // to fetch
  output logic             stall,
  // latch to execute
  output logic             de_valid,
  output de_pkg::op_t      de_op,
  output de_pkg::word_t    de_pc,
  output de_pkg::word_t    de_rs1_val,
  output de_pkg::word_t    de_rs2_val,
  output de_pkg::word_t    de_imm,
  output de_pkg::regno_t   de_rd,
  output logic             de_is_br,
  output logic             de_is_jmp,
  output logic             de_rd_mem,
  output logic             de_wr_mem,
  output logic             de_wr_reg
);

  de_pkg::op_t       op;
  de_pkg::imm_kind_t imm_kind;
  de_pkg::regno_t    rs1;
  de_pkg::regno_t    rs2;
  de_pkg::regno_t    rd;
  de_pkg::word_t     imm;
  de_pkg::word_t     rs1_val;
  de_pkg::word_t     rs2_val;
  logic              use_rs1;
  logic              use_rs2;
  logic              wr_reg;
  logic              is_br;
  logic              is_jmp;
  logic              rd_mem;
  logic              wr_mem;

  inst_decoder i_inst_decoder (
    .valid    (fe_valid),
    .inst     (fe_inst),
    .op       (op),
    .imm_kind (imm_kind),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd       (rd),
    .use_rs1  (use_rs1),
    .use_rs2  (use_rs2),
    .wr_reg   (wr_reg),
    .is_br    (is_br),
    .is_jmp   (is_jmp),
    .rd_mem   (rd_mem),
    .wr_mem   (wr_mem)
  );

  imm_gen i_imm_gen (
    .inst     (fe_inst),
    .imm_kind (imm_kind),
    .imm      (imm)
  );

  reg_file i_reg_file (
    .clk      (clk),
    .reset    (reset),
    .rs1      (rs1),
    .rs2      (rs2),
    .wr_en    (wb_wr_reg),
    .wr_regno (wb_regno),
    .wr_data  (wb_regval),
    .rs1_val  (rs1_val),
    .rs2_val  (rs2_val)
  );

  scoreboard i_scoreboard (
    .clk       (clk),
    .reset     (reset),
    .rs1       (rs1),
    .rs2       (rs2),
    .rd        (rd),
    .use_rs1   (use_rs1),
    .use_rs2   (use_rs2),
    .wr_reg    (wr_reg),
    .flush     (flush),
    .wb_wr_reg (wb_wr_reg),
    .wb_regno  (wb_regno),
    .stall     (stall)
  );

  //////////////////////////////
  // output latch, bubble on stall

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      de_valid   <= 1'b0;
      de_op      <= de_pkg::OP_INVALID;
      de_pc      <= '0;
      de_rs1_val <= '0;
      de_rs2_val <= '0;
      de_imm     <= '0;
      de_rd      <= '0;
      de_is_br   <= 1'b0;
      de_is_jmp  <= 1'b0;
      de_rd_mem  <= 1'b0;
      de_wr_mem  <= 1'b0;
      de_wr_reg  <= 1'b0;
    end else if (stall) begin
      de_valid   <= 1'b0;
      de_op      <= de_pkg::OP_INVALID;
      de_pc      <= '0;
      de_rs1_val <= '0;
      de_rs2_val <= '0;
      de_imm     <= '0;
      de_rd      <= '0;
      de_is_br   <= 1'b0;
      de_is_jmp  <= 1'b0;
      de_rd_mem  <= 1'b0;
      de_wr_mem  <= 1'b0;
      de_wr_reg  <= 1'b0;
    end else begin
      de_valid   <= fe_valid;
      de_op      <= op;
      de_pc      <= fe_pc;
      de_rs1_val <= rs1_val;
      de_rs2_val <= rs2_val;
      de_imm     <= imm;
      de_rd      <= rd;
      de_is_br   <= is_br;
      de_is_jmp  <= is_jmp;
      de_rd_mem  <= rd_mem;
      de_wr_mem  <= wr_mem;
      de_wr_reg  <= wr_reg;
    end
  end

endmodule

`default_nettype wire

//--- design/imm_gen.sv
`timescale 1ns/100ps
`default_nettype none

module imm_gen (
  input  de_pkg::inst_t     inst,
  input  de_pkg::imm_kind_t imm_kind,
  output de_pkg::word_t     imm
);

  logic sign;

  assign sign = inst[31];  // every format takes its sign from bit 31

  always_comb begin
    case (imm_kind)
      de_pkg::IMM_I: imm = {{20{sign}}, inst[31:20]};
      de_pkg::IMM_S: imm = {{20{sign}}, inst[31:25], inst[11:7]};
      de_pkg::IMM_B: imm = {{20{sign}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      de_pkg::IMM_U: imm = {inst[31:12], 12'b0};
      de_pkg::IMM_J: begin
        // scrambled 20-bit jump offset
        imm = {{12{sign}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      default:       imm = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- design/inst_decoder.sv
`timescale 1ns/100ps
`default_nettype none

`include "de_macros.svh"

module inst_decoder (
  input  logic              valid,
  input  de_pkg::inst_t     inst,
  output de_pkg::op_t       op,
  output de_pkg::imm_kind_t imm_kind,
  output de_pkg::regno_t    rs1,
  output de_pkg::regno_t    rs2,
  output de_pkg::regno_t    rd,
  output logic              use_rs1,
  output logic              use_rs2,
  output logic              wr_reg,
  output logic              is_br,
  output logic              is_jmp,
  output logic              rd_mem,
  output logic              wr_mem
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       writes_rd;  // op class produces a register result

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  assign rs1 = inst[19:15];
  assign rs2 = inst[24:20];
  assign rd  = inst[11:7];

  //////////////////////////////
  // opcode match

  always_comb begin
    op = de_pkg::OP_INVALID;  // also covers an empty slot
    if (valid) begin
      case (opcode)
        `OPC_OP: begin
          case ({funct7, funct3})
            {`F7_BASE, `F3_ADD}:   op = de_pkg::OP_ADD;
            {`F7_ALT, `F3_ADD}:    op = de_pkg::OP_SUB;
            {`F7_BASE, `F3_AND}:   op = de_pkg::OP_AND;
            {`F7_BASE, `F3_OR}:    op = de_pkg::OP_OR;
            {`F7_BASE, `F3_XOR}:   op = de_pkg::OP_XOR;
            {`F7_BASE, `F3_SLT}:   op = de_pkg::OP_SLT;
            {`F7_BASE, `F3_SLTU}:  op = de_pkg::OP_SLTU;
            {`F7_ALT, `F3_SR}:     op = de_pkg::OP_SRA;
            {`F7_BASE, `F3_SR}:    op = de_pkg::OP_SRL;
            {`F7_BASE, `F3_SLL}:   op = de_pkg::OP_SLL;
            {`F7_MULDIV, `F3_MUL}: op = de_pkg::OP_MUL;
            default:               op = de_pkg::OP_INVALID;
          endcase
        end
        `OPC_OP_IMM: begin
          case (funct3)
            `F3_ADD:  op = de_pkg::OP_ADDI;
            `F3_AND:  op = de_pkg::OP_ANDI;
            `F3_OR:   op = de_pkg::OP_ORI;
            `F3_XOR:  op = de_pkg::OP_XORI;
            `F3_SLT:  op = de_pkg::OP_SLTI;
            `F3_SLTU: op = de_pkg::OP_SLTIU;
            `F3_SLL:  if (funct7 == `F7_BASE) op = de_pkg::OP_SLLI;
            `F3_SR: begin
              if (funct7 == `F7_BASE)
                op = de_pkg::OP_SRLI;
              else if (funct7 == `F7_ALT)
                op = de_pkg::OP_SRAI;
            end
            default:  op = de_pkg::OP_INVALID;
          endcase
        end
        `OPC_LUI:    op = de_pkg::OP_LUI;
        `OPC_AUIPC:  op = de_pkg::OP_AUIPC;
        `OPC_JAL:    op = de_pkg::OP_JAL;
        `OPC_LOAD:   if (funct3 == `F3_WORD) op = de_pkg::OP_LW;
        `OPC_STORE:  if (funct3 == `F3_WORD) op = de_pkg::OP_SW;
        `OPC_JALR:   if (funct3 == `F3_JALR) op = de_pkg::OP_JALR;
        `OPC_BRANCH: begin
          case (funct3)
            `F3_BEQ:  op = de_pkg::OP_BEQ;
            `F3_BNE:  op = de_pkg::OP_BNE;
            `F3_BLT:  op = de_pkg::OP_BLT;
            `F3_BGE:  op = de_pkg::OP_BGE;
            `F3_BLTU: op = de_pkg::OP_BLTU;
            `F3_BGEU: op = de_pkg::OP_BGEU;
            default:  op = de_pkg::OP_INVALID;
          endcase
        end
        default: op = de_pkg::OP_INVALID;
      endcase
    end
  end

  //////////////////////////////
  // format and control flags

  always_comb begin
    imm_kind  = de_pkg::IMM_NONE;
    use_rs1   = 1'b0;
    use_rs2   = 1'b0;
    writes_rd = 1'b0;
    is_br     = 1'b0;
    is_jmp    = 1'b0;
    rd_mem    = 1'b0;
    wr_mem    = 1'b0;
    case (op)
      de_pkg::OP_ADD, de_pkg::OP_SUB, de_pkg::OP_AND, de_pkg::OP_OR,
      de_pkg::OP_XOR, de_pkg::OP_SLT, de_pkg::OP_SLTU, de_pkg::OP_SRA,
      de_pkg::OP_SRL, de_pkg::OP_SLL, de_pkg::OP_MUL: begin
        use_rs1   = 1'b1;
        use_rs2   = 1'b1;
        writes_rd = 1'b1;
      end
      de_pkg::OP_ADDI, de_pkg::OP_ANDI, de_pkg::OP_ORI, de_pkg::OP_XORI,
      de_pkg::OP_SLTI, de_pkg::OP_SLTIU, de_pkg::OP_SRAI, de_pkg::OP_SRLI,
      de_pkg::OP_SLLI, de_pkg::OP_LW, de_pkg::OP_JALR: begin
        imm_kind  = de_pkg::IMM_I;
        use_rs1   = 1'b1;
        writes_rd = 1'b1;
        rd_mem    = (op == de_pkg::OP_LW);
        is_jmp    = (op == de_pkg::OP_JALR);
      end
      de_pkg::OP_SW: begin
        imm_kind = de_pkg::IMM_S;
        use_rs1  = 1'b1;
        use_rs2  = 1'b1;
        wr_mem   = 1'b1;
      end
      de_pkg::OP_BEQ, de_pkg::OP_BNE, de_pkg::OP_BLT, de_pkg::OP_BGE,
      de_pkg::OP_BLTU, de_pkg::OP_BGEU: begin
        imm_kind = de_pkg::IMM_B;
        use_rs1  = 1'b1;
        use_rs2  = 1'b1;
        is_br    = 1'b1;
      end
      de_pkg::OP_LUI, de_pkg::OP_AUIPC: begin
        imm_kind  = de_pkg::IMM_U;
        writes_rd = 1'b1;
      end
      de_pkg::OP_JAL: begin
        imm_kind  = de_pkg::IMM_J;
        writes_rd = 1'b1;
        is_jmp    = 1'b1;
      end
      default: ;  // invalid, nothing used or written
    endcase
  end

  assign wr_reg = writes_rd && (rd != '0);  // x0 never gets a write

endmodule

`default_nettype wire

//--- design/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

`include "de_macros.svh"

module reg_file (
  input  logic           clk,
  input  logic           reset,
  input  de_pkg::regno_t rs1,
  input  de_pkg::regno_t rs2,
  input  logic           wr_en,
  input  de_pkg::regno_t wr_regno,
  input  de_pkg::word_t  wr_data,
  output de_pkg::word_t  rs1_val,
  output de_pkg::word_t  rs2_val
);

  de_pkg::word_t regs [`REG_COUNT];

  // single write port from write-back
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && (wr_regno != '0)) begin  // x0 stays zero
      regs[wr_regno] <= wr_data;
    end
  end

  // reads are combinational, a write shows up the cycle after
  assign rs1_val = regs[rs1];
  assign rs2_val = regs[rs2];

endmodule

`default_nettype wire

//--- design/scoreboard.sv
`timescale 1ns/100ps
`default_nettype none

`include "de_macros.svh"

module scoreboard (
  input  logic           clk,
  input  logic           reset,
  input  de_pkg::regno_t rs1,
  input  de_pkg::regno_t rs2,
  input  de_pkg::regno_t rd,
  input  logic           use_rs1,
  input  logic           use_rs2,
  input  logic           wr_reg,
  input  logic           flush,
  input  logic           wb_wr_reg,
  input  de_pkg::regno_t wb_regno,
  output logic           stall
);

  logic [`REG_COUNT-1:0] pending;  // one bit per register, write in flight
  logic                  hazard;

  // read-after-write on any source the instruction really uses
  assign hazard = (use_rs1 && pending[rs1]) || (use_rs2 && pending[rs2]);
  assign stall  = flush || hazard;

  //////////////////////////////
  // pending bits

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pending <= '0;
    end else begin
      if (wb_wr_reg)
        pending[wb_regno] <= 1'b0;
      // issued writer marks rd, wins over a clear of the same register
      if (wr_reg && !stall)
        pending[rd] <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+design
design/de_pkg.sv
design/inst_decoder.sv
design/imm_gen.sv
design/reg_file.sv
design/scoreboard.sv
design/decode_stage.sv
sim/decode_stage_sva.sv
sim/decode_stage_tb.sv

//--- sim/decode_stage_sva.sv
`timescale 1ns/100ps
`default_nettype none

module decode_stage_sva (
  input logic           clk,
  input logic           reset,
  input logic           stall,
  input logic           de_valid,
  input logic           de_wr_reg,
  input de_pkg::regno_t de_rd
);

  int fails = 0;  // assertion failures so far

  // a stalled slot leaves a bubble in the latch
  stall_gives_bubble: assert property (
    @(posedge clk) disable iff (reset) stall |=> !de_valid
  ) else begin
    fails++;
    $error("stall was not followed by a bubble in the latch");
  end

  wr_reg_not_x0: assert property (
    @(posedge clk) disable iff (reset) de_wr_reg |-> (de_rd != '0)
  ) else begin
    fails++;
    $error("register write issued with rd equal to x0");
  end

  // first edge after reset release sees an empty latch
  empty_after_reset: assert property (
    @(posedge clk) $fell(reset) |-> !de_valid
  ) else begin
    fails++;
    $error("latch not empty in the cycle after reset");
  end

endmodule

bind decode_stage decode_stage_sva i_decode_stage_sva (
  .clk       (clk),
  .reset     (reset),
  .stall     (stall),
  .de_valid  (de_valid),
  .de_wr_reg (de_wr_reg),
  .de_rd     (de_rd)
);

`default_nettype wire

//--- sim/decode_stage_tb.sv
`timescale 1ns/100ps
`default_nettype none

module decode_stage_tb;

  localparam int phase_cycles = 1100;
  localparam int max_cycles   = 2 * phase_cycles + 1800;  // random phases plus directed, drains

  // RV32 major opcodes
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_auipc  = 7'b0010111;
  localparam logic [6:0] opc_load   = 7'b0000011;
  localparam logic [6:0] opc_store  = 7'b0100011;
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_jalr   = 7'b1100111;
  localparam logic [6:0] opc_branch = 7'b1100011;

  logic           clk;
  logic           reset;
  logic           fe_valid;
  de_pkg::inst_t  fe_inst;
  de_pkg::word_t  fe_pc;
  logic           flush;
  logic           wb_wr_reg;
  de_pkg::regno_t wb_regno;
  de_pkg::word_t  wb_regval;
  logic           stall;
  logic           de_valid;
  de_pkg::op_t    de_op;
  de_pkg::word_t  de_pc;
  de_pkg::word_t  de_rs1_val;
  de_pkg::word_t  de_rs2_val;
  de_pkg::word_t  de_imm;
  de_pkg::regno_t de_rd;
  logic           de_is_br;
  logic           de_is_jmp;
  logic           de_rd_mem;
  logic           de_wr_mem;
  logic           de_wr_reg;

  // reference model state
  logic [31:0]    m_regs [32];
  logic [31:0]    m_pend;
  int             wb_q_reg [$];
  int             wb_q_due [$];
  int             last_due;
  int             cyc;
  int             ticks;
  int             checks;
  int             errors;
  logic [31:0]    seed;
  logic           held;  // fetch holds its slot after a stall

  // slot currently offered by fetch, with its expected decode
  logic           cur_valid;
  logic [31:0]    cur_inst;
  logic [31:0]    cur_pc;
  logic [31:0]    cur_imm;
  de_pkg::op_t    cur_op;

  decode_stage i_decode_stage (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    ticks <= ticks + 1;
    if (ticks == max_cycles) begin
      $display("timeout: run still busy after %0d cycles", max_cycles);
      $display("** FAIL **");
      $finish;
    end
  end

  function automatic logic [31:0] rand32();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic int rand_below(input int n);
    return int'((rand32() >> 8) % n);
  endfunction

  // {opcode, funct3, funct7} per operation, from the RV32IM encoding tables
  function automatic logic [16:0] enc_of(input de_pkg::op_t op);
    case (op)
      de_pkg::OP_ADD:   return {opc_op, 3'b000, 7'b0000000};
      de_pkg::OP_SUB:   return {opc_op, 3'b000, 7'b0100000};
      de_pkg::OP_AND:   return {opc_op, 3'b111, 7'b0000000};
      de_pkg::OP_OR:    return {opc_op, 3'b110, 7'b0000000};
      de_pkg::OP_XOR:   return {opc_op, 3'b100, 7'b0000000};
      de_pkg::OP_SLT:   return {opc_op, 3'b010, 7'b0000000};
      de_pkg::OP_SLTU:  return {opc_op, 3'b011, 7'b0000000};
      de_pkg::OP_SRA:   return {opc_op, 3'b101, 7'b0100000};
      de_pkg::OP_SRL:   return {opc_op, 3'b101, 7'b0000000};
      de_pkg::OP_SLL:   return {opc_op, 3'b001, 7'b0000000};
      de_pkg::OP_MUL:   return {opc_op, 3'b000, 7'b0000001};
      de_pkg::OP_ADDI:  return {opc_op_imm, 3'b000, 7'b0000000};
      de_pkg::OP_ANDI:  return {opc_op_imm, 3'b111, 7'b0000000};
      de_pkg::OP_ORI:   return {opc_op_imm, 3'b110, 7'b0000000};
      de_pkg::OP_XORI:  return {opc_op_imm, 3'b100, 7'b0000000};
      de_pkg::OP_SLTI:  return {opc_op_imm, 3'b010, 7'b0000000};
      de_pkg::OP_SLTIU: return {opc_op_imm, 3'b011, 7'b0000000};
      de_pkg::OP_SRAI:  return {opc_op_imm, 3'b101, 7'b0100000};
      de_pkg::OP_SRLI:  return {opc_op_imm, 3'b101, 7'b0000000};
      de_pkg::OP_SLLI:  return {opc_op_imm, 3'b001, 7'b0000000};
      de_pkg::OP_LUI:   return {opc_lui, 10'b0};
      de_pkg::OP_AUIPC: return {opc_auipc, 10'b0};
      de_pkg::OP_LW:    return {opc_load, 3'b010, 7'b0};
      de_pkg::OP_SW:    return {opc_store, 3'b010, 7'b0};
      de_pkg::OP_JAL:   return {opc_jal, 10'b0};
      de_pkg::OP_JALR:  return {opc_jalr, 3'b000, 7'b0};
      de_pkg::OP_BEQ:   return {opc_branch, 3'b000, 7'b0};
      de_pkg::OP_BNE:   return {opc_branch, 3'b001, 7'b0};
      de_pkg::OP_BLT:   return {opc_branch, 3'b100, 7'b0};
      de_pkg::OP_BGE:   return {opc_branch, 3'b101, 7'b0};
      de_pkg::OP_BLTU:  return {opc_branch, 3'b110, 7'b0};
      de_pkg::OP_BGEU:  return {opc_branch, 3'b111, 7'b0};
      default:          return {7'b1111111, 10'b0};
    endcase
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %s: got %h, expected %h (cycle %0d)", name, got, exp, cyc);
    end
  endtask

  // scatter the chosen immediate into the format of the operation
  task automatic build_slot(input de_pkg::op_t op, input logic [4:0] rd, input logic [4:0] rs1,
                            input logic [4:0] rs2, input logic [31:0] r);
    logic [16:0] enc;
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] i12;
    logic [12:0] b13;
    logic [20:0] j21;
    enc = enc_of(op);
    opc = enc[16:10];
    f3  = enc[9:7];
    f7  = enc[6:0];
    i12 = r[11:0];
    b13 = {r[12:1], 1'b0};
    j21 = {r[20:1], 1'b0};
    cur_valid = 1'b1;
    cur_op    = op;
    cur_pc    = {r[15:0], r[31:18], 2'b00};
    case (opc)
      opc_op: begin
        cur_inst = {f7, rs2, rs1, f3, rd, opc};
        cur_imm  = '0;
      end
      opc_op_imm, opc_load, opc_jalr: begin
        if (opc == opc_op_imm && (f3 == 3'b001 || f3 == 3'b101))
          i12 = {f7, r[4:0]};  // shift amount under funct7
        cur_inst = {i12, rs1, f3, rd, opc};
        cur_imm  = {{20{i12[11]}}, i12};
      end
      opc_store: begin
        cur_inst = {i12[11:5], rs2, rs1, f3, i12[4:0], opc};
        cur_imm  = {{20{i12[11]}}, i12};
      end
      opc_branch: begin
        cur_inst = {b13[12], b13[10:5], rs2, rs1, f3, b13[4:1], b13[11], opc};
        cur_imm  = {{19{b13[12]}}, b13};
      end
      opc_lui, opc_auipc: begin
        cur_inst = {r[31:12], rd, opc};
        cur_imm  = {r[31:12], 12'b0};
      end
      default: begin  // jal
        cur_inst = {j21[20], j21[10:1], j21[11], j21[19:12], rd, opc};
        cur_imm  = {{11{j21[20]}}, j21};
      end
    endcase
  endtask

  function automatic logic [4:0] pick_reg();
    if (rand_below(4) == 0)
      return 5'(rand_below(32));
    return 5'(rand_below(8));  // small set, so hazards are frequent
  endfunction

  task automatic random_slot;
    int          sel;
    logic [31:0] w;
    build_slot(de_pkg::op_t'(1 + rand_below(32)), pick_reg(), pick_reg(), pick_reg(), rand32());
    sel = rand_below(16);
    if (sel == 0) begin
      cur_valid = 1'b0;
    end else if (sel == 1) begin
      w        = rand32();
      cur_inst = {w[31:7], 7'b1111111};  // no such opcode
      cur_op   = de_pkg::OP_INVALID;
    end
  endtask

  task automatic idle_slot;
    cur_valid = 1'b0;
    cur_inst  = '0;
    cur_pc    = '0;
    cur_imm   = '0;
    cur_op    = de_pkg::OP_INVALID;
  endtask

  task automatic pick_wb(input bit x0_tries);
    wb_wr_reg = 1'b0;
    wb_regno  = '0;
    wb_regval = '0;
    if (wb_q_due.size() > 0 && wb_q_due[0] <= cyc) begin
      wb_wr_reg = 1'b1;
      wb_regno  = 5'(wb_q_reg.pop_front());
      wb_regval = rand32();
      void'(wb_q_due.pop_front());
    end else if (x0_tries && rand_below(16) == 0) begin
      wb_wr_reg = 1'b1;  // stray write to x0
      wb_regval = rand32();
    end
  endtask

  //////////////////////////////
  // one clock of the stage against the model

  task automatic cycle;
    logic [6:0]  opc;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic        vop;
    logic        u1;
    logic        u2;
    logic        wr;
    logic        st;
    logic [4:0]  e_flags;
    logic [31:0] e_rs1;
    logic [31:0] e_rs2;
    int          due;
    fe_valid = cur_valid;
    fe_inst  = cur_inst;
    fe_pc    = cur_pc;
    #10;
    opc = cur_inst[6:0];
    rs1 = cur_inst[19:15];
    rs2 = cur_inst[24:20];
    rd  = cur_inst[11:7];
    vop = cur_valid && (cur_op != de_pkg::OP_INVALID);
    u1  = vop && !(opc inside {opc_lui, opc_auipc, opc_jal});
    u2  = vop && (opc inside {opc_op, opc_store, opc_branch});
    wr  = vop && !(opc inside {opc_store, opc_branch}) && (rd != 5'd0);
    st  = flush || (u1 && m_pend[rs1]) || (u2 && m_pend[rs2]);
    check("stall", stall, st);
    e_flags = {vop && opc == opc_branch, vop && (opc == opc_jal || opc == opc_jalr),
               vop && opc == opc_load, vop && opc == opc_store, wr};
    if (st)
      e_flags = '0;
    // operands as the latch sees them, before this edge's write-back
    e_rs1 = m_regs[rs1];
    e_rs2 = m_regs[rs2];
    // the edge itself: write-back first, then the issued writer marks rd
    if (wb_wr_reg) begin
      if (wb_regno != 5'd0)
        m_regs[wb_regno] = wb_regval;
      m_pend[wb_regno] = 1'b0;
    end
    if (wr && !st) begin
      m_pend[rd] = 1'b1;
      due = cyc + 1 + rand_below(6);
      if (due <= last_due)
        due = last_due + 1;  // single write-back port, in order
      last_due = due;
      wb_q_reg.push_back(rd);
      wb_q_due.push_back(due);
    end
    @(posedge clk);
    #1;
    check("de_valid", de_valid, !st && cur_valid);
    check("de_op", de_op, (!st && vop) ? cur_op : de_pkg::OP_INVALID);
    check("de_pc", de_pc, st ? '0 : cur_pc);
    check("de_rs1_val", de_rs1_val, st ? '0 : e_rs1);
    check("de_rs2_val", de_rs2_val, st ? '0 : e_rs2);
    check("de_imm", de_imm, (!st && vop) ? cur_imm : '0);
    check("de_rd", de_rd, st ? '0 : rd);
    check("de_is_br", de_is_br, e_flags[4]);
    check("de_is_jmp", de_is_jmp, e_flags[3]);
    check("de_rd_mem", de_rd_mem, e_flags[2]);
    check("de_wr_mem", de_wr_mem, e_flags[1]);
    check("de_wr_reg", de_wr_reg, e_flags[0]);
    held = st;
    cyc++;
    #1;
  endtask

  task automatic drain;
    idle_slot();
    flush = 1'b0;
    while (wb_q_due.size() > 0) begin
      pick_wb(1'b0);
      cycle();
    end
  endtask

  task automatic read_all_regs;
    for (int i = 0; i < 32; i++) begin
      build_slot(de_pkg::OP_ADD, 5'd0, 5'(i), 5'(31 - i), rand32());
      pick_wb(1'b0);
      flush = 1'b0;
      cycle();
    end
  endtask

  task automatic random_phase(input int n, input bit flush_on);
    held = 1'b0;
    repeat (n) begin
      pick_wb(1'b1);
      flush = flush_on && (rand_below(10) == 0);
      if (!held)
        random_slot();
      cycle();
    end
  endtask

  task automatic report_test(input string name, input int err0, input int cyc0);
    $display("test %-14s cycles %5d  errors %0d", name, cyc - cyc0, errors - err0);
  endtask

  initial begin
    int e0;
    int c0;
    reset     = 1'b1;
    fe_valid  = 1'b0;
    fe_inst   = '0;
    fe_pc     = '0;
    flush     = 1'b0;
    wb_wr_reg = 1'b0;
    wb_regno  = '0;
    wb_regval = '0;
    seed      = 32'h53b8;
    m_pend    = '0;
    last_due  = 0;
    cyc       = 0;
    ticks     = 0;
    checks    = 0;
    errors    = 0;
    held      = 1'b0;
    for (int i = 0; i < 32; i++)
      m_regs[i] = '0;
    idle_slot();
    repeat (8) @(posedge clk);
    #2;
    reset = 1'b0;

    // reset state, then every register through a decoded read
    e0 = errors;
    c0 = cyc;
    check("de_valid", de_valid, 1'b0);
    check("de_wr_reg", de_wr_reg, 1'b0);
    check("de_is_br", de_is_br, 1'b0);
    check("de_is_jmp", de_is_jmp, 1'b0);
    check("de_rd_mem", de_rd_mem, 1'b0);
    check("de_wr_mem", de_wr_mem, 1'b0);
    check("stall", stall, 1'b0);
    read_all_regs();
    report_test("reset", e0, c0);

    e0 = errors;
    c0 = cyc;
    random_phase(phase_cycles, 1'b0);
    drain();
    read_all_regs();
    report_test("decode_hazard", e0, c0);

    e0 = errors;
    c0 = cyc;
    random_phase(phase_cycles, 1'b1);
    drain();
    read_all_regs();
    report_test("flush", e0, c0);

    // x0 targets and stray write-backs to x0
    e0 = errors;
    c0 = cyc;
    repeat (12) begin
      build_slot(de_pkg::op_t'(1 + rand_below(32)), 5'd0, pick_reg(), pick_reg(), rand32());
      flush     = 1'b0;
      wb_wr_reg = 1'b1;
      wb_regno  = 5'd0;
      wb_regval = rand32() | 32'h1;
      cycle();
      build_slot(de_pkg::OP_ADD, 5'd1 + 5'(rand_below(7)), 5'd0, 5'd0, rand32());
      pick_wb(1'b0);
      cycle();
    end
    drain();
    report_test("reg_zero", e0, c0);

    errors += i_decode_stage.i_decode_stage_sva.fails;  // bound assertion failures
    $display("tests 4, checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire
